/* src/lab_pkg.sv */
package lab_pkg;

   //////////////////////////////////////////////////
   // sizes and timing
   //////////////////////////////////////////////////
   localparam int LFSR_WIDTH        = 5;
   localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 5'd1;
   localparam int LFSR_STEP_CYCLES  = 16;  // slow random step
   localparam int COLOR_FAST_CYCLES = 20;  // random mode
   localparam int COLOR_SLOW_CYCLES = 200; // key mode
   localparam int HEX_DIGITS        = 6;
   localparam int NUM_KEYS          = 17;

   localparam int LFSR_STEP_W = $clog2(LFSR_STEP_CYCLES);
   localparam int COLOR_CNT_W = $clog2(COLOR_SLOW_CYCLES);

   typedef logic [LFSR_STEP_W-1:0] step_cnt_t;
   typedef logic [COLOR_CNT_W-1:0] color_cnt_t;

   //////////////////////////////////////////////////
   // keyboard event codes
   //////////////////////////////////////////////////
   // make codes from scan set 2
   localparam logic [7:0] SC_MAKE_1     = 8'h16;
   localparam logic [7:0] SC_MAKE_2     = 8'h1E;
   localparam logic [7:0] SC_MAKE_3     = 8'h26;
   localparam logic [7:0] SC_MAKE_4     = 8'h25;
   localparam logic [7:0] SC_MAKE_5     = 8'h2E;
   localparam logic [7:0] SC_MAKE_6     = 8'h36;
   localparam logic [7:0] SC_MAKE_7     = 8'h3D;
   localparam logic [7:0] SC_MAKE_8     = 8'h3E;
   localparam logic [7:0] SC_MAKE_F1    = 8'h05;
   localparam logic [7:0] SC_MAKE_F2    = 8'h06;
   localparam logic [7:0] SC_MAKE_N     = 8'h31;
   localparam logic [7:0] SC_MAKE_M     = 8'h3A;
   localparam logic [7:0] SC_MAKE_SPACE = 8'h29;
   localparam logic [7:0] SC_MAKE_LEFT  = 8'h6B; // arrows come from the E0 page
   localparam logic [7:0] SC_MAKE_RIGHT = 8'h74;
   localparam logic [7:0] SC_MAKE_UP    = 8'h75;
   localparam logic [7:0] SC_MAKE_DOWN  = 8'h72;

   // break code is the make code with bit 7 set
   localparam logic [7:0] SC_BREAK_1     = 8'h96;
   localparam logic [7:0] SC_BREAK_2     = 8'h9E;
   localparam logic [7:0] SC_BREAK_3     = 8'hA6;
   localparam logic [7:0] SC_BREAK_4     = 8'hA5;
   localparam logic [7:0] SC_BREAK_5     = 8'hAE;
   localparam logic [7:0] SC_BREAK_6     = 8'hB6;
   localparam logic [7:0] SC_BREAK_7     = 8'hBD;
   localparam logic [7:0] SC_BREAK_8     = 8'hBE;
   localparam logic [7:0] SC_BREAK_F1    = 8'h85;
   localparam logic [7:0] SC_BREAK_F2    = 8'h86;
   localparam logic [7:0] SC_BREAK_N     = 8'hB1;
   localparam logic [7:0] SC_BREAK_M     = 8'hBA;
   localparam logic [7:0] SC_BREAK_SPACE = 8'hA9;
   localparam logic [7:0] SC_BREAK_LEFT  = 8'hEB;
   localparam logic [7:0] SC_BREAK_RIGHT = 8'hF4;
   localparam logic [7:0] SC_BREAK_UP    = 8'hF5;
   localparam logic [7:0] SC_BREAK_DOWN  = 8'hF2;

   // index i matches bit i of held_keys_t with key 1 on top
   localparam logic [NUM_KEYS-1:0][7:0] KEY_MAKE_CODES = {
      SC_MAKE_1, SC_MAKE_2, SC_MAKE_3, SC_MAKE_4, SC_MAKE_5, SC_MAKE_6,
      SC_MAKE_7, SC_MAKE_8, SC_MAKE_F1, SC_MAKE_F2, SC_MAKE_N, SC_MAKE_M,
      SC_MAKE_SPACE, SC_MAKE_LEFT, SC_MAKE_RIGHT, SC_MAKE_UP, SC_MAKE_DOWN
   };
   localparam logic [NUM_KEYS-1:0][7:0] KEY_BREAK_CODES = {
      SC_BREAK_1, SC_BREAK_2, SC_BREAK_3, SC_BREAK_4, SC_BREAK_5, SC_BREAK_6,
      SC_BREAK_7, SC_BREAK_8, SC_BREAK_F1, SC_BREAK_F2, SC_BREAK_N, SC_BREAK_M,
      SC_BREAK_SPACE, SC_BREAK_LEFT, SC_BREAK_RIGHT, SC_BREAK_UP, SC_BREAK_DOWN
   };

   //////////////////////////////////////////////////
   // bundled signals
   //////////////////////////////////////////////////
   typedef struct packed {
      logic       ready;
      logic [7:0] code;
   } kbd_event_t;

   typedef struct packed {
      logic key_1;
      logic key_2;
      logic key_3;
      logic key_4;
      logic key_5;
      logic key_6;
      logic key_7;
      logic key_8;
      logic key_f1;
      logic key_f2;
      logic key_n;
      logic key_m;
      logic key_space;
      logic key_left;
      logic key_right;
      logic key_up;
      logic key_down;
   } held_keys_t;

   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   typedef struct packed {
      logic        on;
      logic [11:0] rgb444; // 4:4:4 with red on top
   } cursor_px_t;

   typedef struct packed {
      logic on;
      rgb_t rgb;
   } trace_px_t;

   typedef struct packed {
      logic [2:0] flags;
      logic [1:0] control;
   } color_status_t;

endpackage

/* src/held_key_tracker.sv */
`timescale 1ns/1ps

module held_key_tracker
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  lab_pkg::kbd_event_t kbd_event,
   output lab_pkg::held_keys_t held_keys
);

   logic [lab_pkg::NUM_KEYS-1:0] held_q; // one level per key in held_keys_t order

   //////////////////////////////////////////////////
   // make sets a level and break clears it
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_q <= '0;
      end
      else if (kbd_event.ready)
      begin
         for (int i = 0; i < lab_pkg::NUM_KEYS; i++)
         begin
            if (kbd_event.code == lab_pkg::KEY_MAKE_CODES[i])
            begin
               held_q[i] <= 1'b1;
            end
            else if (kbd_event.code == lab_pkg::KEY_BREAK_CODES[i])
            begin
               held_q[i] <= 1'b0;
            end
         end
      end
   end

   // unknown codes fall through the table and change nothing
   assign held_keys = lab_pkg::held_keys_t'(held_q);

endmodule

/* src/lfsr_stepper.sv */
`timescale 1ns/1ps

module lfsr_stepper
(
   input  logic                           CLK_25MHZ,
   input  logic                           reset_from_key,
   output logic [lab_pkg::LFSR_WIDTH-1:0] lfsr_value
);

   lab_pkg::step_cnt_t step_cnt;
   logic               step;

   // clock enable for each LFSR step
   assign step = (step_cnt == lab_pkg::step_cnt_t'(lab_pkg::LFSR_STEP_CYCLES - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         step_cnt <= '0;
      end
      else if (step)
      begin
         step_cnt <= '0;
      end
      else
      begin
         step_cnt <= step_cnt + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // x^5 + x^3 + 1 with 31 states and no zero state
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr_value <= lab_pkg::LFSR_SEED;
      end
      else if (step)
      begin
         lfsr_value <= {lfsr_value[3:0], lfsr_value[4] ^ lfsr_value[2]};
      end
   end

endmodule

/* src/color_change_gen.sv */
`timescale 1ns/1ps

module color_change_gen
(
   input  logic                           CLK_25MHZ,
   input  logic                           reset_from_key,
   input  logic [lab_pkg::LFSR_WIDTH-1:0] lfsr_value,
   input  logic                           random_mode,
   input  logic [2:0]                     key_n,          // active-low push keys 3..1
   input  logic [1:0]                     manual_control,
   input  logic                           startup,
   output lab_pkg::color_status_t         color_status,
   output logic                           color_irq
);

   lab_pkg::color_status_t status_d;
   lab_pkg::color_cnt_t    tick_cnt;
   lab_pkg::color_cnt_t    tick_last;
   logic                   mode_q;
   logic                   mode_changed;
   logic                   tick;

   //////////////////////////////////////////////////
   // source select
   //////////////////////////////////////////////////
   always_comb
   begin
      if (random_mode)
      begin
         status_d.flags   = lfsr_value[4:2];
         status_d.control = lfsr_value[1:0];
      end
      else
      begin
         status_d.flags   = ~key_n;
         status_d.control = manual_control;
      end
   end

   assign tick_last = random_mode ? lab_pkg::color_cnt_t'(lab_pkg::COLOR_FAST_CYCLES - 1)
                                  : lab_pkg::color_cnt_t'(lab_pkg::COLOR_SLOW_CYCLES - 1);
   assign mode_changed = (random_mode != mode_q);
   assign tick         = !mode_changed && (tick_cnt == tick_last);

   //////////////////////////////////////////////////
   // tick timer, status and irq
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         mode_q       <= 1'b0;
         tick_cnt     <= '0;
         color_status <= '0;
         color_irq    <= 1'b0;
      end
      else
      begin
         mode_q       <= random_mode;
         color_status <= status_d;
         if (mode_changed || tick)
         begin
            tick_cnt <= '0; // a mode switch starts a fresh period
         end
         else
         begin
            tick_cnt <= tick_cnt + 1'b1;
         end
         // no irq when nothing is flagged once startup is done
         color_irq <= tick && ((|color_status.flags) || !startup);
      end
   end

endmodule

/* src/hex_color_display.sv */
`timescale 1ns/1ps

module hex_color_display
(
   input  lab_pkg::rgb_t                         color_rgb,
   output logic [lab_pkg::HEX_DIGITS-1:0][6:0]   hex
);

   logic [lab_pkg::HEX_DIGITS*4-1:0] nibbles;

   // active-low segments g..a
   function automatic logic [6:0] seg_decode(input logic [3:0] nib);
      logic [6:0] seg;
      case (nib)
         4'h0:    seg = 7'b1000000;
         4'h1:    seg = 7'b1111001;
         4'h2:    seg = 7'b0100100;
         4'h3:    seg = 7'b0110000;
         4'h4:    seg = 7'b0011001;
         4'h5:    seg = 7'b0010010;
         4'h6:    seg = 7'b0000010;
         4'h7:    seg = 7'b1111000;
         4'h8:    seg = 7'b0000000;
         4'h9:    seg = 7'b0010000;
         4'hA:    seg = 7'b0001000;
         4'hB:    seg = 7'b0000011; // lower case b
         4'hC:    seg = 7'b1000110;
         4'hD:    seg = 7'b0100001; // lower case d
         4'hE:    seg = 7'b0000110;
         default: seg = 7'b0001110;
      endcase
      return seg;
   endfunction

   // blue low nibble ends up on digit 0 and red high on digit 5
   assign nibbles = color_rgb;

   always_comb
   begin
      for (int i = 0; i < lab_pkg::HEX_DIGITS; i++)
      begin
         hex[i] = seg_decode(nibbles[4*i +: 4]);
      end
   end

endmodule

/* src/pixel_priority_mux.sv */
`timescale 1ns/1ps

module pixel_priority_mux
(
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  lab_pkg::cursor_px_t cursor_px,
   input  lab_pkg::trace_px_t  trace_a_px,
   input  lab_pkg::trace_px_t  trace_b_px,
   input  lab_pkg::rgb_t       background,
   output lab_pkg::rgb_t       video_rgb
);

   lab_pkg::rgb_t cursor_rgb;
   lab_pkg::rgb_t pixel_d;

   // 4-bit fields go to the top of each byte
   assign cursor_rgb.red   = {cursor_px.rgb444[11:8], 4'h0};
   assign cursor_rgb.green = {cursor_px.rgb444[7:4], 4'h0};
   assign cursor_rgb.blue  = {cursor_px.rgb444[3:0], 4'h0};

   //////////////////////////////////////////////////
   // layer priority
   //////////////////////////////////////////////////
   always_comb
   begin
      if (cursor_px.on)
      begin
         pixel_d = cursor_rgb;
      end
      else if (trace_a_px.on)
      begin
         pixel_d = trace_a_px.rgb;
      end
      else if (trace_b_px.on)
      begin
         pixel_d = trace_b_px.rgb;
      end
      else
      begin
         pixel_d = background;
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         video_rgb <= '0;
      else
         video_rgb <= pixel_d;
   end

endmodule

/* src/dds_lab_top.sv */
`timescale 1ns/1ps

module dds_lab_top
(
   input  logic                                CLK_25MHZ,
   input  logic                                reset_from_key,
   input  lab_pkg::kbd_event_t                 kbd_event,
   input  logic [2:0]                          key_n,
   input  logic                                random_mode,
   input  logic [1:0]                          manual_control,
   input  logic                                startup,
   input  lab_pkg::rgb_t                       color_rgb,     // current colour from the processor
   input  lab_pkg::cursor_px_t                 cursor_px,
   input  lab_pkg::trace_px_t                  trace_a_px,
   input  lab_pkg::trace_px_t                  trace_b_px,
   input  lab_pkg::rgb_t                       background,
   output lab_pkg::held_keys_t                 held_keys,
   output logic [lab_pkg::LFSR_WIDTH-1:0]      lfsr_value,
   output lab_pkg::color_status_t              color_status,
   output logic                                color_irq,
   output logic [lab_pkg::HEX_DIGITS-1:0][6:0] hex,
   output lab_pkg::rgb_t                       video_rgb
);

   //////////////////////////////////////////////////
   // keyboard and random source
   //////////////////////////////////////////////////
   held_key_tracker held_key_tracker_i
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .kbd_event      (kbd_event),
      .held_keys      (held_keys)
   );

   lfsr_stepper lfsr_stepper_i
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_value     (lfsr_value)
   );

   // lfsr also feeds the colour generator in random mode
   color_change_gen color_change_gen_i
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_value     (lfsr_value),
      .random_mode    (random_mode),
      .key_n          (key_n),
      .manual_control (manual_control),
      .startup        (startup),
      .color_status   (color_status),
      .color_irq      (color_irq)
   );

   //////////////////////////////////////////////////
   // display side
   //////////////////////////////////////////////////
   hex_color_display hex_color_display_i
   (
      .color_rgb (color_rgb),
      .hex       (hex)
   );

   pixel_priority_mux pixel_priority_mux_i
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .cursor_px      (cursor_px),
      .trace_a_px     (trace_a_px),
      .trace_b_px     (trace_b_px),
      .background     (background),
      .video_rgb      (video_rgb)
   );

endmodule

/* tests/dds_lab_properties.sv */
`timescale 1ns/1ps

module dds_lab_properties
(
   input logic                CLK_25MHZ,
   input logic                reset_from_key,
   input lab_pkg::kbd_event_t kbd_event,
   input lab_pkg::held_keys_t held_keys,
   input logic [4:0]          lfsr_value,
   input logic                color_irq
);

   irq_single_cycle: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      color_irq |=> !color_irq)
      else $error("color_irq held for two cycles");

   held_stable_idle: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      !kbd_event.ready |=> $stable(held_keys))
      else $error("held_keys changed without a ready event");

   lfsr_nonzero: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_value != '0)
      else $error("lfsr_value reached zero");

endmodule

bind dds_lab_top dds_lab_properties props_i
(
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .kbd_event      (kbd_event),
   .held_keys      (held_keys),
   .lfsr_value     (lfsr_value),
   .color_irq      (color_irq)
);

/* tests/dds_lab_checker.sv */
`timescale 1ns/1ps

module dds_lab_checker
(
   input logic                         CLK_25MHZ,
   input logic                         reset_from_key,
   input logic [2:0]                   key_n,
   input logic                         random_mode,
   input logic [1:0]                   manual_control,
   input lab_pkg::rgb_t                color_rgb,
   input lab_pkg::cursor_px_t          cursor_px,
   input lab_pkg::trace_px_t           trace_a_px,
   input lab_pkg::trace_px_t           trace_b_px,
   input lab_pkg::rgb_t                background,
   input lab_pkg::held_keys_t          held_keys,
   input logic [4:0]                   lfsr_value,
   input lab_pkg::color_status_t       color_status,
   input logic                         color_irq,
   input logic [5:0][6:0]              hex,
   input lab_pkg::rgb_t                video_rgb
);

   // active-low segments g..a for digits 0 to F
   localparam logic [6:0] SEG [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                       7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

   string         cur_test = "startup";
   int            mismatches = 0;
   int            failures = 0;
   bit            armed = 0;
   bit            quiet = 0;
   logic [4:0]    lfsr_m;
   int            step_m;
   logic [4:0]    status_m;
   lab_pkg::rgb_t pixel_m;
   int unsigned   cyc = 0;
   int unsigned   last_irq = 0;
   bit            have_last = 0;
   bit            prev_mode = 0;
   int            ignore = 0;

   task automatic start_test(input string name);
      cur_test = name;
   endtask

   task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      mismatches++;
   endtask

   task automatic report_failure(input string msg);
      $display("error in %s: %s", cur_test, msg);
      failures++;
   endtask

   task automatic check_held(input logic [31:0] exp);
      if (32'(held_keys) !== {15'd0, exp[16:0]})
         mismatch("held_keys", {15'd0, exp[16:0]}, 32'(held_keys));
   endtask

   task automatic check_hex();
      logic [23:0] rgb;
      rgb = color_rgb;
      for (int i = 0; i < 6; i++)
      begin
         if (hex[i] !== SEG[rgb[4*i +: 4]])
            mismatch($sformatf("hex[%0d]", i), 32'(SEG[rgb[4*i +: 4]]), 32'(hex[i]));
      end
   endtask

   task automatic set_quiet(input bit on);
      quiet = on;
      have_last = 0; // spacing restarts after a quiet stretch
   endtask

   //////////////////////////////////////////////////
   // per-cycle models checked against pre-edge state
   //////////////////////////////////////////////////
   always @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         armed = 1;
         lfsr_m = 5'd1;
         step_m = 0;
         status_m = '0;
         pixel_m = '0;
         have_last = 0;
         prev_mode = random_mode;
      end
      else if (armed)
      begin
         cyc++;
         if (5'(color_status) !== status_m)
            mismatch("color_status", 32'(status_m), 32'(color_status));
         status_m = random_mode ? lfsr_m : {~key_n, manual_control};

         if (lfsr_value !== lfsr_m)
            mismatch("lfsr_value", 32'(lfsr_m), 32'(lfsr_value));
         if (step_m == lab_pkg::LFSR_STEP_CYCLES - 1)
         begin
            step_m = 0;
            lfsr_m = {lfsr_m[3:0], lfsr_m[4] ^ lfsr_m[2]}; // x^5+x^3+1
         end
         else
            step_m++;

         if (video_rgb !== pixel_m)
            mismatch("video_rgb", 32'(pixel_m), 32'(video_rgb));
         if (cursor_px.on)
            pixel_m = {cursor_px.rgb444[11:8], 4'h0, cursor_px.rgb444[7:4], 4'h0,
                       cursor_px.rgb444[3:0], 4'h0};
         else if (trace_a_px.on)
            pixel_m = trace_a_px.rgb;
         else if (trace_b_px.on)
            pixel_m = trace_b_px.rgb;
         else
            pixel_m = background;

         // irq spacing is tracked within one mode at a time
         if (random_mode != prev_mode)
         begin
            have_last = 0;
            ignore = 2; // a pulse from the old mode may still be in flight
         end
         prev_mode = random_mode;
         if (color_irq && ignore == 0)
         begin
            if (quiet)
               report_failure("color_irq pulsed while all flags were clear after startup");
            else if (have_last && (cyc - last_irq) != (random_mode ?
                     lab_pkg::COLOR_FAST_CYCLES : lab_pkg::COLOR_SLOW_CYCLES))
               mismatch("irq spacing", random_mode ? lab_pkg::COLOR_FAST_CYCLES :
                        lab_pkg::COLOR_SLOW_CYCLES, cyc - last_irq);
            last_irq = cyc;
            have_last = 1;
         end
         if (ignore > 0)
            ignore--;
      end
   end

endmodule

/* tests/dds_lab_tb.sv */
`timescale 1ns/1ps

module dds_lab_tb;

   logic                   CLK_25MHZ;
   logic                   reset_from_key;
   lab_pkg::kbd_event_t    kbd_event;
   logic [2:0]             key_n;
   logic                   random_mode;
   logic [1:0]             manual_control;
   logic                   startup;
   lab_pkg::rgb_t          color_rgb;
   lab_pkg::cursor_px_t    cursor_px;
   lab_pkg::trace_px_t     trace_a_px;
   lab_pkg::trace_px_t     trace_b_px;
   lab_pkg::rgb_t          background = '0;
   lab_pkg::held_keys_t    held_keys;
   logic [4:0]             lfsr_value;
   lab_pkg::color_status_t color_status;
   logic                   color_irq;
   logic [5:0][6:0]        hex;
   lab_pkg::rgb_t          video_rgb;

   dds_lab_top dds_lab_top_i (.*);
   dds_lab_checker checker_i (.*);

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;
   end

   // fresh random background on every cycle
   always @(negedge CLK_25MHZ)
   begin
      logic [31:0] r;
      r = $urandom;
      background <= r[23:0];
   end

   task automatic wait_irq_pulses(input int n, input int limit);
      int seen;
      int cycles;
      seen = 0;
      cycles = 0;
      while (seen < n && cycles < limit)
      begin
         @(negedge CLK_25MHZ);
         if (color_irq)
            seen++;
         cycles++;
      end
      if (seen < n)
         checker_i.report_failure($sformatf("only %0d of %0d irq pulses came in time", seen, n));
   endtask

   task automatic idle_kbd();
      logic [31:0] r;
      r = $urandom;
      kbd_event = {1'b0, r[7:0]};
   endtask

   //////////////////////////////////////////////////
   // pattern-driven stimulus
   //////////////////////////////////////////////////
   initial
   begin
      int          fd;
      int          n;
      string       line;
      string       name;
      string       op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      void'($urandom(13674));
      reset_from_key = 1'b1;
      kbd_event = '0;
      key_n = 3'b111;
      random_mode = 1'b0;
      manual_control = 2'b00;
      startup = 1'b1;
      color_rgb = '0;
      cursor_px = '0;
      trace_a_px = '0;
      trace_b_px = '0;
      repeat (2) @(posedge CLK_25MHZ);
      @(negedge CLK_25MHZ);
      reset_from_key = 1'b0;
      fd = $fopen("tests/dds_lab_patterns.txt", "r");
      if (fd == 0)
         checker_i.report_failure("could not open the pattern file");
      while (fd != 0 && !$feof(fd))
      begin
         n = $fgets(line, fd);
         if (n == 0 || line.len() < 3 || line[0] == "#")
            continue;
         n = $sscanf(line, "%s %s %h %h %h", name, op, a, b, c);
         if (n != 5)
         begin
            checker_i.report_failure("could not parse a pattern line");
            continue;
         end
         checker_i.start_test(name);
         @(negedge CLK_25MHZ);
         if (op == "KEY")
         begin
            kbd_event = {a[0], b[7:0]};
            @(negedge CLK_25MHZ);
            idle_kbd();
            checker_i.check_held(c);
         end
         else if (op == "PIX")
         begin
            cursor_px = a[12:0];
            trace_a_px = b[24:0];
            trace_b_px = c[24:0];
            repeat (2) @(negedge CLK_25MHZ);
         end
         else if (op == "HEX")
         begin
            color_rgb = a[23:0];
            @(posedge CLK_25MHZ);
            checker_i.check_hex();
         end
         else if (op == "RUN")
            repeat (a) @(negedge CLK_25MHZ);
         else if (op == "KMODE")
         begin
            random_mode = 1'b0;
            key_n = a[2:0];
            manual_control = b[1:0];
            startup = c[0];
            wait_irq_pulses(3, 4 * lab_pkg::COLOR_SLOW_CYCLES);
         end
         else if (op == "RMODE")
         begin
            random_mode = 1'b1;
            startup = 1'b0; // keeps zero-flag LFSR states from hiding a tick
            wait_irq_pulses(a, (a + 2) * lab_pkg::COLOR_FAST_CYCLES);
         end
         else if (op == "QUIET")
         begin
            random_mode = 1'b0;
            key_n = 3'b111;
            startup = 1'b1;
            repeat (3) @(negedge CLK_25MHZ);
            checker_i.set_quiet(1);
            repeat (a) @(negedge CLK_25MHZ);
            checker_i.set_quiet(0);
         end
         else
            checker_i.report_failure({"unknown operation ", op});
      end
      if (fd != 0)
         $fclose(fd);
      repeat (4) @(negedge CLK_25MHZ);
      $display("mismatches: %0d, other errors: %0d", checker_i.mismatches, checker_i.failures);
      if (checker_i.mismatches == 0 && checker_i.failures == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   // whole-run limit
   initial
   begin
      repeat (20000) @(posedge CLK_25MHZ);
      checker_i.report_failure("simulation ran past its cycle limit");
      $display("mismatches: %0d, other errors: %0d", checker_i.mismatches, checker_i.failures);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* tests/dds_lab_patterns.txt */
# name op a b c : KEY a=ready b=code c=held_keys after | PIX a=cursor b=trace_a c=trace_b
# HEX a=color_rgb | RUN a=cycles | KMODE a=key_n b=ctrl c=startup | RMODE a=pulses | QUIET a=cycles
lfsr_period RUN 258 0 0
make_1 KEY 1 16 10000
make_2 KEY 1 1E 18000
make_3 KEY 1 26 1C000
make_4 KEY 1 25 1E000
make_5 KEY 1 2E 1F000
make_6 KEY 1 36 1F800
make_7 KEY 1 3D 1FC00
make_8 KEY 1 3E 1FE00
make_f1 KEY 1 05 1FF00
make_f2 KEY 1 06 1FF80
make_n KEY 1 31 1FFC0
make_m KEY 1 3A 1FFE0
make_space KEY 1 29 1FFF0
make_left KEY 1 6B 1FFF8
make_right KEY 1 74 1FFFC
make_up KEY 1 75 1FFFE
make_down KEY 1 72 1FFFF
unknown_code KEY 1 55 1FFFF
break_1 KEY 1 96 0FFFF
break_2 KEY 1 9E 07FFF
break_3 KEY 1 A6 03FFF
break_4 KEY 1 A5 01FFF
break_5 KEY 1 AE 00FFF
break_6 KEY 1 B6 007FF
break_7 KEY 1 BD 003FF
break_8 KEY 1 BE 001FF
break_f1 KEY 1 85 000FF
break_f2 KEY 1 86 0007F
break_n KEY 1 B1 0003F
break_m KEY 1 BA 0001F
break_space KEY 1 A9 0000F
ready_low KEY 0 29 0000F
break_left KEY 1 EB 00007
break_right KEY 1 F4 00003
break_up KEY 1 F5 00001
break_down KEY 1 F2 00000
lfsr_period2 RUN 258 0 0
key_mode_a KMODE 6 2 1
key_mode_b KMODE 0 1 1
key_startup KMODE 7 3 0
key_quiet QUIET 450 0 0
random_mode RMODE 6 0 0
key_mode_c KMODE 5 0 1
hex_a HEX 123456 0 0
hex_b HEX ABCDEF 0 0
hex_c HEX 90F7E8 0 0
pix_cursor PIX 1ABC 1FFFFFF 1000000
pix_trace_a PIX 0ABC 1123456 1654321
pix_trace_b PIX 0FFF 0123456 1654321
pix_back PIX 0FFF 0FFFFFF 0EEEEEE

/* compile.f */
src/lab_pkg.sv
src/held_key_tracker.sv
src/lfsr_stepper.sv
src/color_change_gen.sv
src/hex_color_display.sv
src/pixel_priority_mux.sv
src/dds_lab_top.sv
tests/dds_lab_properties.sv
tests/dds_lab_checker.sv
tests/dds_lab_tb.sv

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dds_lab_tb -f compile.f -o dds_lab_sim
./obj_dir/dds_lab_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
   exit 1
fi
exit 0
